// File: Makefile
TOP = tb_fprint_checker
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module $(TOP) -f fprint_checker_top.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: fprint_checker_top.f
hw/fprint_pkg.sv
hw/csr_decode.sv
hw/csr_registers.sv
hw/fprint_compare.sv
hw/fprint_checker_top.sv
test/tb_fprint_checker.sv

// File: hw/csr_decode.sv
module csr_decode import fprint_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      capture,
	input  logic                      csr_read,
	input  logic                      csr_write,
	input  logic [csr_addr_width-1:0] csr_address,
	input  logic [data_width-1:0]     csr_writedata,
	output csr_kind_t                 kind,
	output logic                      is_write,
	output logic [task_id_width-1:0]  dir_offset,
	output logic [1:0]                assign_row,
	output logic [3:0]                assign_index,
	output logic [3:0]                assign_core,
	output logic [data_width-1:0]     wdata
);

	logic [csr_addr_width-1:0] addr_q;
	logic [data_width-1:0]     data_q;

	// Request held here so the host inputs are free during the head/tail wait
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			addr_q   <= '0;
			is_write <= 1'b0;
		end else if (capture) begin
			addr_q   <= csr_address;
			is_write <= csr_write;
		end
	end

	always_ff @(posedge clk) begin
		if (capture)
			data_q <= csr_writedata;
	end

	// Exact offsets first, then directory, then the core table
	always_comb begin
		kind = kind_none;
		if (addr_q == exception_offset)
			kind = kind_exception;
		else if (addr_q == success_offset)
			kind = kind_success;
		else if (addr_q == fail_offset)
			kind = kind_fail;
		else if (addr_q[7:4] == dir_start_code)
			kind = kind_dir_start;
		else if (addr_q[7:4] == dir_end_code)
			kind = kind_dir_end;
		else if (addr_q[5:0] == core_assign_offset)
			kind = kind_core_assign;
	end

	assign dir_offset   = addr_q[task_id_width-1:0];
	assign assign_row   = addr_q[7:6];
	assign assign_index = data_q[7:4];
	assign assign_core  = data_q[3:0];
	assign wdata        = data_q;

endmodule

// File: hw/csr_registers.sv
module csr_registers import fprint_pkg::*; #(
	parameter int ptr_width = 10
) (
	input  logic                     clk,
	input  logic                     reset,

	// Host request and its decoded form
	input  logic                     csr_read,
	input  logic                     csr_write,
	input  csr_kind_t                kind,
	input  logic                     is_write,
	input  logic [task_id_width-1:0] dir_offset,
	input  logic [1:0]               assign_row,
	input  logic [3:0]               assign_index,
	input  logic [3:0]               assign_core,
	input  logic [data_width-1:0]    wdata,
	output logic                     capture,
	output logic [data_width-1:0]    csr_readdata,
	output logic                     csr_waitrequest,

	// Comparator report
	input  logic                     comp_status_write,
	input  logic [task_id_width-1:0] comp_task,
	input  logic                     comp_collision_detected,
	output logic                     comp_status_ack,

	// Fingerprint side
	input  logic [3:0]               physical_core_id,
	input  logic [task_id_width-1:0] fprint_task_id,
	output logic                     logical_core_id,

	// Head/tail set toward the comparator
	input  logic                     head_tail_ack,
	output logic                     set_head_tail,
	output logic [task_id_width-1:0] head_tail_offset,
	output logic [ptr_width-1:0]     head_tail_data,

	// Directory read ports
	output logic [ptr_width-1:0]     start_pointer_ex,
	output logic [ptr_width-1:0]     end_pointer_ex,
	output logic [ptr_width-1:0]     start_pointer_comp,
	output logic [ptr_width-1:0]     end_pointer_comp,
	output logic                     irq
);

	csr_state_t state;

	logic [data_width-1:0] exception_reg;
	logic [num_tasks-1:0]  success_reg;
	logic [num_tasks-1:0]  fail_reg;
	logic [ptr_width-1:0]  start_mem [num_tasks];
	logic [ptr_width-1:0]  end_mem [num_tasks];
	logic [3:0]            core_table [2][num_tasks];
	logic                  reg_write;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= state_idle;
		end else begin
			case (state)
				state_idle: begin
					if (csr_write)
						state <= state_csr_write;
					else if (csr_read)
						state <= state_csr_read;
					else if (comp_status_write && !irq)
						state <= state_comp_write;
				end
				// A start pointer write also resets the task in the comparator
				state_csr_write: begin
					if (kind == kind_dir_start)
						state <= state_set_head_tail;
					else
						state <= state_wait_release;
				end
				state_csr_read:
					state <= state_wait_release;
				state_wait_release:
					state <= state_idle;
				state_comp_write:
					state <= state_comp_ack;
				state_comp_ack:
					state <= state_idle;
				state_set_head_tail: begin
					if (head_tail_ack)
						state <= state_wait_release;
				end
				default:
					state <= state_idle;
			endcase
		end
	end

	assign capture          = (state == state_idle) && (csr_read || csr_write);
	assign reg_write        = (state == state_csr_write) && is_write;
	assign csr_waitrequest  = (state != state_wait_release);
	assign comp_status_ack  = (state == state_comp_ack);
	assign set_head_tail    = (state == state_set_head_tail);
	assign head_tail_offset = dir_offset;
	assign head_tail_data   = wdata[ptr_width-1:0];
	assign irq              = exception_reg[irq_bit];

	// Unmapped addresses read as zero
	always_comb begin
		case (kind)
			kind_exception: csr_readdata = exception_reg;
			kind_success:   csr_readdata = {{(data_width-num_tasks){1'b0}}, success_reg};
			kind_fail:      csr_readdata = {{(data_width-num_tasks){1'b0}}, fail_reg};
			default:        csr_readdata = '0;
		endcase
	end

	// Software write clears both bitmaps along with the exception word
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			exception_reg <= '0;
			success_reg   <= '0;
			fail_reg      <= '0;
		end else if (reg_write && kind == kind_exception) begin
			exception_reg <= wdata;
			success_reg   <= '0;
			fail_reg      <= '0;
		end else if (state == state_comp_write) begin
			exception_reg[irq_bit]                    <= 1'b1;
			exception_reg[task_lsb +: task_id_width]  <= comp_task;
			exception_reg[collision_bit]              <= comp_collision_detected;
			success_reg[comp_task]                    <= !comp_collision_detected;
			fail_reg[comp_task]                       <= comp_collision_detected;
		end
	end

	// Pointer directory, two registered read ports each
	always_ff @(posedge clk) begin
		if (reg_write && kind == kind_dir_start)
			start_mem[dir_offset] <= wdata[ptr_width-1:0];
		if (reg_write && kind == kind_dir_end)
			end_mem[dir_offset] <= wdata[ptr_width-1:0];
		start_pointer_ex   <= start_mem[fprint_task_id];
		end_pointer_ex     <= end_mem[fprint_task_id];
		start_pointer_comp <= start_mem[comp_task];
		end_pointer_comp   <= end_mem[comp_task];
	end

	// Only rows 0 and 1 exist
	always_ff @(posedge clk) begin
		if (reg_write && kind == kind_core_assign && !assign_row[1])
			core_table[assign_row[0]][assign_index] <= assign_core;
	end

	// Row 1 names the physical core acting as logical copy 1
	assign logical_core_id = (core_table[1][fprint_task_id] == physical_core_id);

endmodule

// File: hw/fprint_checker_top.sv
module fprint_checker_top import fprint_pkg::*; #(
	parameter int ptr_width = 10
) (
	input  logic                      clk,
	input  logic                      reset,

	// Host bus
	input  logic [csr_addr_width-1:0] csr_address,
	input  logic                      csr_read,
	input  logic                      csr_write,
	input  logic [data_width-1:0]     csr_writedata,
	output logic [data_width-1:0]     csr_readdata,
	output logic                      csr_waitrequest,

	// Fingerprint submission from the cores
	input  logic                      fprint_valid,
	input  logic [3:0]                physical_core_id,
	input  logic [task_id_width-1:0]  fprint_task_id,
	input  logic [data_width-1:0]     fprint_crc,

	// Pointer directory exports
	output logic [ptr_width-1:0]      start_pointer_ex,
	output logic [ptr_width-1:0]      end_pointer_ex,
	output logic [ptr_width-1:0]      start_pointer_comp,
	output logic [ptr_width-1:0]      end_pointer_comp,
	output logic                      irq
);

	csr_kind_t                kind;
	logic                     capture;
	logic                     is_write;
	logic [task_id_width-1:0] dir_offset;
	logic [1:0]               assign_row;
	logic [3:0]               assign_index;
	logic [3:0]               assign_core;
	logic [data_width-1:0]    wdata;
	logic                     comp_status_write;
	logic                     comp_status_ack;
	logic [task_id_width-1:0] comp_task;
	logic                     comp_collision_detected;
	logic                     logical_core_id;
	logic                     set_head_tail;
	logic                     head_tail_ack;
	logic [task_id_width-1:0] head_tail_offset;
	logic [ptr_width-1:0]     head_tail_data;

	csr_decode i_decode (
		.clk(clk), .reset(reset), .capture(capture),
		.csr_read(csr_read), .csr_write(csr_write),
		.csr_address(csr_address), .csr_writedata(csr_writedata),
		.kind(kind), .is_write(is_write), .dir_offset(dir_offset),
		.assign_row(assign_row), .assign_index(assign_index),
		.assign_core(assign_core), .wdata(wdata)
	);

	csr_registers #(.ptr_width(ptr_width)) i_registers (
		.clk(clk), .reset(reset),
		.csr_read(csr_read), .csr_write(csr_write), .kind(kind), .is_write(is_write),
		.dir_offset(dir_offset), .assign_row(assign_row), .assign_index(assign_index),
		.assign_core(assign_core), .wdata(wdata), .capture(capture),
		.csr_readdata(csr_readdata), .csr_waitrequest(csr_waitrequest),
		.comp_status_write(comp_status_write), .comp_task(comp_task),
		.comp_collision_detected(comp_collision_detected),
		.comp_status_ack(comp_status_ack),
		.physical_core_id(physical_core_id), .fprint_task_id(fprint_task_id),
		.logical_core_id(logical_core_id), .head_tail_ack(head_tail_ack),
		.set_head_tail(set_head_tail), .head_tail_offset(head_tail_offset),
		.head_tail_data(head_tail_data),
		.start_pointer_ex(start_pointer_ex), .end_pointer_ex(end_pointer_ex),
		.start_pointer_comp(start_pointer_comp), .end_pointer_comp(end_pointer_comp),
		.irq(irq)
	);

	// Head/tail data goes to the fingerprint RAM, which lives outside this unit
	fprint_compare #(.ptr_width(ptr_width)) i_compare (
		.clk(clk), .reset(reset),
		.fprint_valid(fprint_valid), .fprint_task_id(fprint_task_id),
		.fprint_crc(fprint_crc), .logical_core_id(logical_core_id),
		.comp_status_ack(comp_status_ack), .comp_status_write(comp_status_write),
		.comp_task(comp_task), .comp_collision_detected(comp_collision_detected),
		.set_head_tail(set_head_tail),
		.head_tail_offset(head_tail_offset), .head_tail_ack(head_tail_ack)
	);

endmodule

// File: hw/fprint_compare.sv
module fprint_compare import fprint_pkg::*; #(
	parameter int ptr_width = 10
) (
	input  logic                     clk,
	input  logic                     reset,

	// Fingerprint submission
	input  logic                     fprint_valid,
	input  logic [task_id_width-1:0] fprint_task_id,
	input  logic [data_width-1:0]    fprint_crc,
	input  logic                     logical_core_id,

	// Report toward the register block
	input  logic                     comp_status_ack,
	output logic                     comp_status_write,
	output logic [task_id_width-1:0] comp_task,
	output logic                     comp_collision_detected,

	// Head/tail set clears the task
	input  logic                     set_head_tail,
	input  logic [task_id_width-1:0] head_tail_offset,
	output logic                     head_tail_ack
);

	logic [data_width-1:0]    fp_mem [2][num_tasks];
	logic [num_tasks-1:0]     valid_copy0;
	logic [num_tasks-1:0]     valid_copy1;
	logic [num_tasks-1:0]     ready;
	logic [num_tasks-1:0]     candidates;
	logic [task_id_width-1:0] next_task;
	logic                     next_found;
	logic                     ht_clear;

	// Clear taken once, in the cycle before the acknowledge
	assign ht_clear = set_head_tail && !head_tail_ack;
	assign ready    = valid_copy0 & valid_copy1;

	// Tasks being cleared this cycle are not candidates
	always_comb begin
		candidates = ready;
		if (comp_status_ack)
			candidates[comp_task] = 1'b0;
		if (ht_clear)
			candidates[head_tail_offset] = 1'b0;
		next_found = |candidates;
		next_task  = '0;
		// Lowest ready task wins
		for (int i = num_tasks - 1; i >= 0; i--) begin
			if (candidates[i])
				next_task = task_id_width'(i);
		end
	end

	always_ff @(posedge clk) begin
		if (fprint_valid)
			fp_mem[logical_core_id][fprint_task_id] <= fprint_crc;
	end

	// A fresh submission overrides a clear in the same cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_copy0 <= '0;
			valid_copy1 <= '0;
		end else begin
			if (comp_status_ack) begin
				valid_copy0[comp_task] <= 1'b0;
				valid_copy1[comp_task] <= 1'b0;
			end
			if (ht_clear) begin
				valid_copy0[head_tail_offset] <= 1'b0;
				valid_copy1[head_tail_offset] <= 1'b0;
			end
			if (fprint_valid) begin
				if (logical_core_id)
					valid_copy1[fprint_task_id] <= 1'b1;
				else
					valid_copy0[fprint_task_id] <= 1'b1;
			end
		end
	end

	// Report held until acknowledged, then the next ready task follows
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			comp_status_write <= 1'b0;
			comp_task         <= '0;
		end else if (!comp_status_write || comp_status_ack) begin
			comp_status_write <= next_found;
			if (next_found)
				comp_task <= next_task;
		end
	end

	always_ff @(posedge clk) begin
		if ((!comp_status_write || comp_status_ack) && next_found)
			comp_collision_detected <= (fp_mem[0][next_task] != fp_mem[1][next_task]);
	end

	// One-cycle acknowledge
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			head_tail_ack <= 1'b0;
		else
			head_tail_ack <= ht_clear;
	end

endmodule

// File: hw/fprint_pkg.sv
package fprint_pkg;

	// Task and bus widths
	parameter int task_id_width  = 4;
	parameter int num_tasks      = 16;
	parameter int csr_addr_width = 8;
	parameter int data_width     = 32;

	// Register map
	parameter logic [csr_addr_width-1:0] exception_offset = 8'd0;
	parameter logic [csr_addr_width-1:0] success_offset   = 8'd1;
	parameter logic [csr_addr_width-1:0] fail_offset      = 8'd2;

	// Core assignment matches on the low six bits, row in bits 7 to 6
	parameter logic [5:0] core_assign_offset = 6'd3;

	// Pointer directory matches on the upper address nibble
	parameter logic [3:0] dir_start_code = 4'h1;
	parameter logic [3:0] dir_end_code   = 4'h2;

	// Exception register fields
	parameter int irq_bit       = 31;
	parameter int task_lsb      = 4;
	parameter int collision_bit = 0;

	typedef enum logic [2:0] {
		kind_none,
		kind_exception,
		kind_success,
		kind_fail,
		kind_dir_start,
		kind_dir_end,
		kind_core_assign
	} csr_kind_t;

	typedef enum logic [2:0] {
		state_idle,
		state_csr_write,
		state_csr_read,
		state_wait_release,
		state_comp_write,
		state_comp_ack,
		state_set_head_tail
	} csr_state_t;

endpackage

// File: test/tb_fprint_checker.sv
module tb_fprint_checker import fprint_pkg::*; ();

	localparam int ptr_width = 10;
	// Roughly 600 cycles of bus and fingerprint traffic, limit kept well above
	localparam int timeout_cycles = 4000;
	localparam logic [3:0] copy0_core = 4'd2;
	localparam logic [3:0] copy1_core = 4'd5;

	logic clk = 1'b0;
	logic reset, csr_read, csr_write, csr_waitrequest, fprint_valid, irq;
	logic [csr_addr_width-1:0] csr_address;
	logic [data_width-1:0] csr_writedata, csr_readdata, fprint_crc;
	logic [3:0] physical_core_id;
	logic [task_id_width-1:0] fprint_task_id;
	logic [ptr_width-1:0] start_pointer_ex, end_pointer_ex, start_pointer_comp, end_pointer_comp;

	// Reference model state
	logic [ptr_width-1:0] ref_start [num_tasks];
	logic [ptr_width-1:0] ref_end [num_tasks];
	logic [data_width-1:0] ref_fp [2][num_tasks];
	logic ref_valid [2][num_tasks];
	logic [data_width-1:0] ref_exception;
	logic [num_tasks-1:0] ref_success, ref_fail;

	logic [31:0] rng_state = 32'hd17f;
	int cycle_count = 0;
	logic ptr_check_en = 1'b0;
	logic [task_id_width-1:0] ex_task_q = '0;

	fprint_checker_top #(.ptr_width(ptr_width)) i_dut (.*);

	always #10 clk = ~clk;

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input logic [data_width-1:0] got,
			input logic [data_width-1:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_ptr(input string name, input logic [ptr_width-1:0] got,
			input logic [ptr_width-1:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("Fail at %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == timeout_cycles)
			stop_on_error("Timeout, the tests did not finish within the cycle limit");
	end

	// Registered read port follows the task id of the previous cycle
	always @(posedge clk) begin
		if (ptr_check_en) begin
			check_ptr("start_pointer_ex", start_pointer_ex, ref_start[ex_task_q]);
			check_ptr("end_pointer_ex", end_pointer_ex, ref_end[ex_task_q]);
		end
		ex_task_q <= fprint_task_id;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic next_random(output logic [31:0] r);
		rng_state = xorshift(rng_state);
		r = rng_state;
	endtask

	// Report fields replace their bits, the rest of the word is kept
	function automatic logic [data_width-1:0] exception_after_report(
			input logic [data_width-1:0] old_word, input logic [task_id_width-1:0] tid,
			input logic collision);
		logic [data_width-1:0] word;
		word = old_word;
		word[irq_bit] = 1'b1;
		word[task_lsb +: task_id_width] = tid;
		word[collision_bit] = collision;
		return word;
	endfunction

	function automatic int lowest_ready_task();
		for (int i = 0; i < num_tasks; i++) begin
			if (ref_valid[0][i] && ref_valid[1][i])
				return i;
		end
		return -1;
	endfunction

	task automatic csr_wr(input logic [csr_addr_width-1:0] addr, input logic [data_width-1:0] data);
		@(posedge clk);
		csr_write <= 1'b1;
		csr_address <= addr;
		csr_writedata <= data;
		@(posedge clk);
		while (csr_waitrequest)
			@(posedge clk);
		csr_write <= 1'b0;
	endtask

	task automatic csr_rd(input logic [csr_addr_width-1:0] addr, output logic [data_width-1:0] data);
		@(posedge clk);
		csr_read <= 1'b1;
		csr_address <= addr;
		@(posedge clk);
		while (csr_waitrequest)
			@(posedge clk);
		data = csr_readdata;
		csr_read <= 1'b0;
	endtask

	task automatic read_expect(input logic [csr_addr_width-1:0] addr, input string name,
			input logic [data_width-1:0] exp);
		logic [data_width-1:0] rdata;
		csr_rd(addr, rdata);
		check_data(name, rdata, exp);
	endtask

	task automatic clear_exception();
		csr_wr(exception_offset, '0);
		ref_exception = '0;
		ref_success = '0;
		ref_fail = '0;
	endtask

	// Copy 1 is the core named in row 1 of the assignment table
	task automatic submit_fprint(input logic [3:0] core, input logic [task_id_width-1:0] tid,
			input logic [data_width-1:0] crc);
		@(posedge clk);
		fprint_valid <= 1'b1;
		physical_core_id <= core;
		fprint_task_id <= tid;
		fprint_crc <= crc;
		@(posedge clk);
		fprint_valid <= 1'b0;
		ref_fp[core == copy1_core][tid] = crc;
		ref_valid[core == copy1_core][tid] = 1'b1;
	endtask

	task automatic expect_report();
		int t;
		logic collision;
		while (!irq)
			@(posedge clk);
		t = lowest_ready_task();
		if (t < 0)
			stop_on_error("An interrupt was raised with no completed pair pending");
		collision = ref_fp[0][t] !== ref_fp[1][t];
		ref_exception = exception_after_report(ref_exception, task_id_width'(t), collision);
		ref_success[t] = !collision;
		ref_fail[t] = collision;
		ref_valid[0][t] = 1'b0;
		ref_valid[1][t] = 1'b0;
		read_expect(exception_offset, "exception", ref_exception);
		read_expect(success_offset, "success", data_width'(ref_success));
		read_expect(fail_offset, "fail", data_width'(ref_fail));
	endtask

	initial begin
		logic [31:0] r;
		logic [task_id_width-1:0] t_a, t_b, t_lo, t_hi;
		reset <= 1'b1;
		csr_read <= 1'b0;
		csr_write <= 1'b0;
		csr_address <= '0;
		csr_writedata <= '0;
		fprint_valid <= 1'b0;
		physical_core_id <= '0;
		fprint_task_id <= '0;
		fprint_crc <= '0;
		ref_exception = '0;
		ref_success = '0;
		ref_fail = '0;
		for (int t = 0; t < num_tasks; t++) begin
			ref_valid[0][t] = 1'b0;
			ref_valid[1][t] = 1'b0;
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// Reset values
		@(posedge clk);
		check_bit("irq", irq, 1'b0);
		check_bit("csr_waitrequest", csr_waitrequest, 1'b1);
		read_expect(exception_offset, "exception", '0);
		read_expect(success_offset, "success", '0);
		read_expect(fail_offset, "fail", '0);

		// Pointer directory, then the execute read port for every task
		for (int t = 0; t < num_tasks; t++) begin
			next_random(r);
			ref_start[t] = r[ptr_width-1:0];
			ref_end[t] = r[ptr_width+15:16];
			csr_wr({dir_start_code, task_id_width'(t)}, data_width'(ref_start[t]));
			csr_wr({dir_end_code, task_id_width'(t)}, data_width'(ref_end[t]));
		end
		ptr_check_en <= 1'b1;
		for (int t = 0; t < num_tasks; t++) begin
			fprint_task_id <= task_id_width'(t);
			@(posedge clk);
		end
		@(posedge clk);
		ptr_check_en <= 1'b0;

		// Physical core 5 acts as copy 1 for all tasks
		for (int t = 0; t < num_tasks; t++)
			csr_wr({2'b01, core_assign_offset}, data_width'({task_id_width'(t), copy1_core}));

		// Matching pair
		next_random(r);
		t_a = r[3:0];
		submit_fprint(copy0_core, t_a, r);
		submit_fprint(copy1_core, t_a, r);
		expect_report();
		check_ptr("start_pointer_comp", start_pointer_comp, ref_start[t_a]);
		check_ptr("end_pointer_comp", end_pointer_comp, ref_end[t_a]);

		// Two collisions held back while the interrupt is pending
		next_random(r);
		t_a = r[3:0];
		t_b = t_a + task_id_width'(r[6:4]) + 4'd1;
		t_lo = (t_a < t_b) ? t_a : t_b;
		t_hi = (t_a < t_b) ? t_b : t_a;
		submit_fprint(copy0_core, t_lo, r);
		submit_fprint(copy1_core, t_lo, ~r);
		submit_fprint(copy0_core, t_hi, r);
		submit_fprint(copy1_core, t_hi, r ^ 32'h10);
		repeat (10) @(posedge clk);
		read_expect(exception_offset, "exception", ref_exception);
		clear_exception();
		expect_report();
		clear_exception();
		expect_report();

		// Start pointer write drops the stored half of a pair
		clear_exception();
		next_random(r);
		t_a = r[3:0];
		submit_fprint(copy0_core, t_a, r);
		ref_start[t_a] = r[ptr_width+7:8];
		csr_wr({dir_start_code, t_a}, data_width'(ref_start[t_a]));
		ref_valid[0][t_a] = 1'b0;
		ref_valid[1][t_a] = 1'b0;
		submit_fprint(copy1_core, t_a, r);
		repeat (20) begin
			@(posedge clk);
			check_bit("irq", irq, 1'b0);
		end
		submit_fprint(copy0_core, t_a, r);
		expect_report();
		check_ptr("start_pointer_comp", start_pointer_comp, ref_start[t_a]);
		check_ptr("end_pointer_comp", end_pointer_comp, ref_end[t_a]);

		$display("test passed");
		$finish;
	end

endmodule
